// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing
TOP       := dma_wh_subsys_tb
FILELIST  := dma_wh_subsys.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== dma_wh_subsys.f ====
verilog/wh_dma_pkg.sv
verilog/wh_link_if.sv
verilog/two_fifo.sv
verilog/cache_dma_to_wormhole.sv
verilog/wh_link_merge.sv
verilog/wh_mem_endpoint.sv
verilog/dma_wh_subsys.sv
test/clock_gen.sv
test/dma_wh_subsys_tb.sv

// ==== test/clock_gen.sv ====
/*
 * testbench clock and synchronous reset
 */

`timescale 1ns/1ns
`default_nettype none

module clock_gen
  #(parameter int period_p       = 8
  , parameter int reset_cycles_p = 8
  )
  (output logic clk_o
  , output logic reset_o
  );

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/dma_wh_subsys_tb.sv ====
/*
 * testbench for the two-port DMA wormhole subsystem
 * table of block writes and reads, reference memory, per-test report
 */

`timescale 1ns/1ns
`default_nettype none

module dma_wh_subsys_tb
  import wh_dma_pkg::*;
  ();

  localparam int block_len_lp   = 4;
  localparam int mem_blocks_lp  = 16;
  localparam int block_bytes_lp = block_len_lp * (flit_width_p / 8);
  localparam int max_tests_lp   = 24;
  localparam int timeout_lp     = 200;

  logic clk;
  logic reset;

  dma_pkt_s [1:0] pkt;
  logic [1:0]     pkt_v;
  logic [1:0]     pkt_yumi;
  flit_t [1:0]    fill_data;
  logic [1:0]     fill_v;
  logic [1:0]     fill_ready;
  flit_t [1:0]    evict_data;
  logic [1:0]     evict_v;
  logic [1:0]     evict_yumi;

  // test table columns
  string                   name_tab [max_tests_lp];
  logic                    port_tab [max_tests_lp];
  logic                    wnr_tab  [max_tests_lp];
  logic [addr_width_p-1:0] addr_tab [max_tests_lp];
  flit_t                   seed_tab [max_tests_lp];
  logic                    bp_tab   [max_tests_lp];
  logic                    pair_tab [max_tests_lp];
  int                      err_tab  [max_tests_lp];
  int                      n_tests;

  flit_t  ref_mem [mem_blocks_lp][block_len_lp];
  int     n_checks;
  int     n_errors;
  logic   hung;
  integer seed;
  int     t;

  clock_gen #(.period_p(8), .reset_cycles_p(8)) clocks (
    .clk_o   (clk)
    ,.reset_o(reset)
  );

  dma_wh_subsys #(
    .block_len_p  (block_len_lp)
    ,.mem_blocks_p(mem_blocks_lp)
  ) uut (
    .clk_i            (clk)
    ,.reset_i         (reset)
    ,.dma_pkt_i       (pkt)
    ,.dma_pkt_v_i     (pkt_v)
    ,.dma_pkt_yumi_o  (pkt_yumi)
    ,.dma_data_o      (fill_data)
    ,.dma_data_v_o    (fill_v)
    ,.dma_data_ready_i(fill_ready)
    ,.dma_data_i      (evict_data)
    ,.dma_data_v_i    (evict_v)
    ,.dma_data_yumi_o (evict_yumi)
  );

  function automatic flit_t block_flit(input flit_t base, input int k);
    return base ^ (flit_t'(k + 1) * 32'h1357_9bdf);
  endfunction

  // block index wraps at the memory depth
  function automatic int block_index(input logic [addr_width_p-1:0] addr);
    return int'((addr / block_bytes_lp) % mem_blocks_lp);
  endfunction

  task automatic add_entry(input string name, input logic port, input logic wnr,
                           input logic [addr_width_p-1:0] addr, input flit_t base,
                           input logic bp, input logic pair);
    name_tab[n_tests] = name;
    port_tab[n_tests] = port;
    wnr_tab[n_tests]  = wnr;
    addr_tab[n_tests] = addr;
    seed_tab[n_tests] = base;
    bp_tab[n_tests]   = bp;
    pair_tab[n_tests] = pair;
    err_tab[n_tests]  = 0;
    n_tests = n_tests + 1;
  endtask

  task automatic check_flit(input int idx, input flit_t exp, input flit_t act);
    n_checks = n_checks + 1;
    if (act !== exp) begin
      $display("** Error: %s flit expected %h actual %h", name_tab[idx], exp, act);
      err_tab[idx] = err_tab[idx] + 1;
      n_errors = n_errors + 1;
    end
  endtask

  task automatic check_bit(input int idx, input logic exp, input logic act);
    n_checks = n_checks + 1;
    if (act !== exp) begin
      $display("** Error: %s level expected %b actual %b", name_tab[idx], exp, act);
      err_tab[idx] = err_tab[idx] + 1;
      n_errors = n_errors + 1;
    end
  endtask

  task automatic check_dma_pkt(input int idx, input dma_pkt_s exp, input dma_pkt_s act);
    n_checks = n_checks + 1;
    if (act !== exp) begin
      $display("** Error: %s request expected %h actual %h", name_tab[idx], exp, act);
      err_tab[idx] = err_tab[idx] + 1;
      n_errors = n_errors + 1;
    end
  endtask

  task automatic note_timeout(input int idx, input string what);
    $display("%s: gave up waiting, %s", name_tab[idx], what);
    err_tab[idx] = err_tab[idx] + 1;
    n_errors = n_errors + 1;
    hung = 1'b1;
  endtask

  task automatic check_reset_levels();
    check_bit(0, 1'b0, pkt_yumi[0]);
    check_bit(0, 1'b0, pkt_yumi[1]);
    check_bit(0, 1'b0, evict_yumi[0]);
    check_bit(0, 1'b0, evict_yumi[1]);
    check_bit(0, 1'b0, fill_v[0]);
    check_bit(0, 1'b0, fill_v[1]);
  endtask

  // returns on the falling edge after the accept
  task automatic offer_request(input int idx, input dma_pkt_s req);
    logic p;
    logic taken;
    int   cycles;

    p = port_tab[idx];
    @(negedge clk);
    pkt[p]   = req;
    pkt_v[p] = 1'b1;
    taken    = 1'b0;
    cycles   = 0;
    while (!taken && !hung) begin
      #1;
      taken = pkt_yumi[p];
      @(negedge clk);
      if (taken) begin
        // accepted packet sits at the head of the bridge request FIFO
        check_dma_pkt(idx, req, p ? uut.bridge1.pkt_lo : uut.bridge0.pkt_lo);
      end
      cycles = cycles + 1;
      if (!taken && cycles > timeout_lp) begin
        note_timeout(idx, "request packet was never accepted");
      end
    end
    pkt_v[p] = 1'b0;
  endtask

  task automatic do_write(input int idx);
    logic     p;
    logic     taken;
    int       sent;
    int       cycles;
    int       blk;
    int       k;
    dma_pkt_s req;

    p   = port_tab[idx];
    blk = block_index(addr_tab[idx]);
    for (k = 0; k < block_len_lp; k++) begin
      ref_mem[blk][k] = block_flit(seed_tab[idx], k);
    end
    req.write_not_read = 1'b1;
    req.addr           = addr_tab[idx];
    offer_request(idx, req);

    evict_data[p] = block_flit(seed_tab[idx], 0);
    evict_v[p]    = 1'b1;
    sent   = 0;
    cycles = 0;
    while (sent < block_len_lp && !hung) begin
      #1;
      taken = evict_yumi[p];
      @(negedge clk);
      if (taken) begin
        sent = sent + 1;
        evict_data[p] = block_flit(seed_tab[idx], sent);
      end
      cycles = cycles + 1;
      if (sent < block_len_lp && cycles > timeout_lp) begin
        note_timeout(idx, "evict data was not all taken");
      end
    end
    evict_v[p] = 1'b0;
  endtask

  task automatic do_read(input int idx);
    logic     p;
    int       got;
    int       cycles;
    int       blk;
    int       k;
    int       rnd;
    flit_t    expect_blk [block_len_lp];
    dma_pkt_s req;

    p   = port_tab[idx];
    blk = block_index(addr_tab[idx]);
    for (k = 0; k < block_len_lp; k++) begin
      expect_blk[k] = ref_mem[blk][k];
    end
    req.write_not_read = 1'b0;
    req.addr           = addr_tab[idx];
    offer_request(idx, req);

    got    = 0;
    cycles = 0;
    while (got < block_len_lp && !hung) begin
      @(negedge clk);
      if (bp_tab[idx]) begin
        rnd = $random(seed);
        fill_ready[p] = rnd[0];
      end else begin
        fill_ready[p] = 1'b1;
      end
      #1;
      if (fill_v[p] && fill_ready[p]) begin
        check_flit(idx, expect_blk[got], fill_data[p]);
        got = got + 1;
      end
      cycles = cycles + 1;
      if (got < block_len_lp && cycles > timeout_lp) begin
        note_timeout(idx, "fill data did not complete");
      end
    end

    // nothing more may follow the block
    @(negedge clk);
    fill_ready[p] = 1'b0;
    if (!hung) begin
      #1;
      check_bit(idx, 1'b0, fill_v[p]);
    end
  endtask

  task automatic run_test(input int idx);
    if (wnr_tab[idx]) begin
      do_write(idx);
    end else begin
      do_read(idx);
    end
  endtask

  task automatic report_test(input int idx);
    $display("test %s: %s", name_tab[idx], (err_tab[idx] == 0) ? "ok" : "failed");
  endtask

  // paired entries run on both ports at once and must use different ports
  task automatic load_table();
    add_entry("reset_levels",   1'b0, 1'b0, 28'h0000000, 32'h0,         1'b0, 1'b0);
    add_entry("wr_p0_blk4",     1'b0, 1'b1, 28'h0000040, 32'ha5a5_0000, 1'b0, 1'b0);
    add_entry("rd_p0_blk4",     1'b0, 1'b0, 28'h0000040, 32'h0,         1'b0, 1'b0);
    add_entry("wr_p1_blk8",     1'b1, 1'b1, 28'h0000080, 32'h5a5a_1100, 1'b0, 1'b0);
    add_entry("rd_p0_blk8",     1'b0, 1'b0, 28'h0000080, 32'h0,         1'b0, 1'b0);
    add_entry("wr_p0_blk12",    1'b0, 1'b1, 28'h00000c0, 32'h0f0f_2200, 1'b0, 1'b1);
    add_entry("wr_p1_blk0",     1'b1, 1'b1, 28'h0000000, 32'hf0f0_3300, 1'b0, 1'b0);
    add_entry("rd_p0_blk12",    1'b0, 1'b0, 28'h00000c0, 32'h0,         1'b0, 1'b1);
    add_entry("rd_p1_blk0",     1'b1, 1'b0, 28'h0000000, 32'h0,         1'b0, 1'b0);
    add_entry("rd_p1_blk4_bp",  1'b1, 1'b0, 28'h0000040, 32'h0,         1'b1, 1'b1);
    add_entry("rd_p0_blk0_bp",  1'b0, 1'b0, 28'h0000000, 32'h0,         1'b1, 1'b0);
    add_entry("wr_p0_blk14",    1'b0, 1'b1, 28'h00001e0, 32'h1234_5678, 1'b0, 1'b0);
    add_entry("wr_p1_alias14",  1'b1, 1'b1, 28'h80001e0, 32'h8765_4321, 1'b0, 1'b0);
    add_entry("rd_p0_blk14_bp", 1'b0, 1'b0, 28'h00001e0, 32'h0,         1'b1, 1'b0);
    add_entry("rd_p1_alias14",  1'b1, 1'b0, 28'h80001e0, 32'h0,         1'b0, 1'b0);
  endtask

  initial begin
    int cycles;

    pkt        = '0;
    // valids held high so a stray accept during reset would show
    pkt_v      = 2'b11;
    fill_ready = 2'b00;
    evict_data = '0;
    evict_v    = 2'b11;
    n_tests    = 0;
    n_checks   = 0;
    n_errors   = 0;
    hung       = 1'b0;
    seed       = 32'h3e91_2bed;
    load_table();

    cycles = 0;
    do begin
      @(negedge clk);
      // request valid drops early in reset
      if (cycles == 1) begin
        pkt_v = 2'b00;
      end
      #1;
      check_reset_levels();
      cycles = cycles + 1;
    end while (reset && cycles < timeout_lp);
    if (reset) begin
      note_timeout(0, "reset was never released");
    end
    repeat (2) begin
      @(negedge clk);
      #1;
      check_reset_levels();
    end
    evict_v = 2'b00;
    report_test(0);

    t = 1;
    while (t < n_tests && !hung) begin
      if (pair_tab[t] && (t + 1 < n_tests)) begin
        fork
          run_test(t);
          run_test(t + 1);
        join
        report_test(t);
        report_test(t + 1);
        t = t + 2;
      end else begin
        run_test(t);
        report_test(t);
        t = t + 1;
      end
    end

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0 && !hung) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cache_dma_to_wormhole.sv ====
/*
 * cache DMA port to wormhole link bridge
 * send FSM for header/addr/evict data, receive FSM for fill data
 */

`timescale 1ns/1ns
`default_nettype none

module cache_dma_to_wormhole
  import wh_dma_pkg::*;
  #(parameter int block_len_p = 4
  , parameter int cid_p       = 0
  )
  (input  logic     clk_i
  , input  logic     reset_i

  , input  dma_pkt_s dma_pkt_i
  , input  logic     dma_pkt_v_i
  , output logic     dma_pkt_yumi_o

  , output flit_t    dma_data_o
  , output logic     dma_data_v_o
  , input  logic     dma_data_ready_i

  , input  flit_t    dma_data_i
  , input  logic     dma_data_v_i
  , output logic     dma_data_yumi_o

  , wh_link_if.client link
  );

  localparam logic [len_width_p-1:0] last_lp = len_width_p'(block_len_p - 1);

  // request packet fifo
  dma_pkt_s pkt_lo;
  logic     pkt_v_lo;
  logic     pkt_ready_lo;
  logic     pkt_yumi_li;

  two_fifo #(.payload_t(dma_pkt_s)) pkt_fifo (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.v_i    (dma_pkt_v_i)
    ,.data_i (dma_pkt_i)
    ,.ready_o(pkt_ready_lo)
    ,.v_o    (pkt_v_lo)
    ,.data_o (pkt_lo)
    ,.yumi_i (pkt_yumi_li)
  );

  // nothing is accepted in reset
  assign dma_pkt_yumi_o = pkt_ready_lo & dma_pkt_v_i & ~reset_i;

  // fill flits from the link
  flit_t ret_data_lo;
  logic  ret_v_lo;
  logic  ret_yumi_li;

  two_fifo #(.payload_t(flit_t)) return_fifo (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.v_i    (link.rev_v)
    ,.data_i (link.rev_data)
    ,.ready_o(link.rev_ready)
    ,.v_o    (ret_v_lo)
    ,.data_o (ret_data_lo)
    ,.yumi_i (ret_yumi_li)
  );

  wh_header_s header_flit;
  assign header_flit.unused         = '0;
  assign header_flit.write_not_read = pkt_lo.write_not_read;
  assign header_flit.cid            = cid_width_p'(cid_p);
  // addr plus data for writes, addr only for reads
  assign header_flit.len = pkt_lo.write_not_read
    ? len_width_p'(1 + block_len_p)
    : len_width_p'(1);

  typedef enum logic [1:0] {
    SEND_RESET,
    SEND_HEADER,
    SEND_ADDR,
    SEND_DATA
  } send_state_e;

  send_state_e send_state_r;
  send_state_e send_state_n;
  logic [len_width_p-1:0] send_cnt_r;
  logic send_up;
  logic send_clear;

  always_comb begin
    send_state_n    = send_state_r;
    pkt_yumi_li     = 1'b0;
    send_up         = 1'b0;
    send_clear      = 1'b0;
    link.fwd_v      = 1'b0;
    link.fwd_data   = dma_data_i;
    dma_data_yumi_o = 1'b0;

    case (send_state_r)
      SEND_RESET: begin
        send_state_n = SEND_HEADER;
      end

      SEND_HEADER: begin
        link.fwd_data = header_flit;
        if (pkt_v_lo) begin
          link.fwd_v = 1'b1;
          if (link.fwd_ready) begin
            send_state_n = SEND_ADDR;
          end
        end
      end

      SEND_ADDR: begin
        link.fwd_data = flit_width_p'(pkt_lo.addr);
        link.fwd_v    = pkt_v_lo;
        if (pkt_v_lo & link.fwd_ready) begin
          pkt_yumi_li  = 1'b1;
          send_state_n = pkt_lo.write_not_read ? SEND_DATA : SEND_HEADER;
        end
      end

      SEND_DATA: begin
        // evict data goes straight through to the link
        link.fwd_v      = dma_data_v_i;
        dma_data_yumi_o = dma_data_v_i & link.fwd_ready;
        if (dma_data_yumi_o) begin
          if (send_cnt_r == last_lp) begin
            send_clear   = 1'b1;
            send_state_n = SEND_HEADER;
          end else begin
            send_up = 1'b1;
          end
        end
      end

      default: begin
        send_state_n = SEND_HEADER;
      end
    endcase
  end

  typedef enum logic [1:0] {
    RECV_RESET,
    RECV_HEADER,
    RECV_DATA
  } recv_state_e;

  recv_state_e recv_state_r;
  recv_state_e recv_state_n;
  logic [len_width_p-1:0] recv_cnt_r;
  logic recv_up;
  logic recv_clear;

  assign dma_data_o = ret_data_lo;

  always_comb begin
    recv_state_n = recv_state_r;
    ret_yumi_li  = 1'b0;
    dma_data_v_o = 1'b0;
    recv_up      = 1'b0;
    recv_clear   = 1'b0;

    case (recv_state_r)
      RECV_RESET: begin
        recv_state_n = RECV_HEADER;
      end

      RECV_HEADER: begin
        // reply header carries nothing the cache needs
        ret_yumi_li = ret_v_lo;
        if (ret_v_lo) begin
          recv_state_n = RECV_DATA;
        end
      end

      RECV_DATA: begin
        dma_data_v_o = ret_v_lo;
        ret_yumi_li  = ret_v_lo & dma_data_ready_i;
        if (ret_yumi_li) begin
          if (recv_cnt_r == last_lp) begin
            recv_clear   = 1'b1;
            recv_state_n = RECV_HEADER;
          end else begin
            recv_up = 1'b1;
          end
        end
      end

      default: begin
        recv_state_n = RECV_HEADER;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_RESET;
      recv_state_r <= RECV_RESET;
      send_cnt_r   <= '0;
      recv_cnt_r   <= '0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      if (send_clear) begin
        send_cnt_r <= '0;
      end else if (send_up) begin
        send_cnt_r <= send_cnt_r + 1'b1;
      end
      if (recv_clear) begin
        recv_cnt_r <= '0;
      end else if (recv_up) begin
        recv_cnt_r <= recv_cnt_r + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dma_wh_subsys.sv ====
/*
 * two cache DMA bridges merged onto one memory endpoint
 */

`timescale 1ns/1ns
`default_nettype none

module dma_wh_subsys
  import wh_dma_pkg::*;
  #(parameter int block_len_p  = 4
  , parameter int mem_blocks_p = 16
  )
  (input  logic                clk_i
  , input  logic                reset_i

  , input  dma_pkt_s [1:0]      dma_pkt_i
  , input  logic [1:0]          dma_pkt_v_i
  , output logic [1:0]          dma_pkt_yumi_o

  , output flit_t [1:0]         dma_data_o
  , output logic [1:0]          dma_data_v_o
  , input  logic [1:0]          dma_data_ready_i

  , input  flit_t [1:0]         dma_data_i
  , input  logic [1:0]          dma_data_v_i
  , output logic [1:0]          dma_data_yumi_o
  );

  wh_link_if link0 ();
  wh_link_if link1 ();
  wh_link_if mem_link ();

  cache_dma_to_wormhole #(.block_len_p(block_len_p), .cid_p(0)) bridge0 (
    .clk_i            (clk_i)
    ,.reset_i         (reset_i)
    ,.dma_pkt_i       (dma_pkt_i[0])
    ,.dma_pkt_v_i     (dma_pkt_v_i[0])
    ,.dma_pkt_yumi_o  (dma_pkt_yumi_o[0])
    ,.dma_data_o      (dma_data_o[0])
    ,.dma_data_v_o    (dma_data_v_o[0])
    ,.dma_data_ready_i(dma_data_ready_i[0])
    ,.dma_data_i      (dma_data_i[0])
    ,.dma_data_v_i    (dma_data_v_i[0])
    ,.dma_data_yumi_o (dma_data_yumi_o[0])
    ,.link            (link0)
  );

  cache_dma_to_wormhole #(.block_len_p(block_len_p), .cid_p(1)) bridge1 (
    .clk_i            (clk_i)
    ,.reset_i         (reset_i)
    ,.dma_pkt_i       (dma_pkt_i[1])
    ,.dma_pkt_v_i     (dma_pkt_v_i[1])
    ,.dma_pkt_yumi_o  (dma_pkt_yumi_o[1])
    ,.dma_data_o      (dma_data_o[1])
    ,.dma_data_v_o    (dma_data_v_o[1])
    ,.dma_data_ready_i(dma_data_ready_i[1])
    ,.dma_data_i      (dma_data_i[1])
    ,.dma_data_v_i    (dma_data_v_i[1])
    ,.dma_data_yumi_o (dma_data_yumi_o[1])
    ,.link            (link1)
  );

  wh_link_merge #(.block_len_p(block_len_p)) merge (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.up0    (link0)
    ,.up1    (link1)
    ,.down   (mem_link)
  );

  wh_mem_endpoint #(
    .block_len_p  (block_len_p)
    ,.mem_blocks_p(mem_blocks_p)
  ) mem (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.link   (mem_link)
  );

endmodule

`default_nettype wire

// ==== verilog/two_fifo.sv ====
/*
 * two-entry valid/ready FIFO with a typed payload
 */

`timescale 1ns/1ns
`default_nettype none

module two_fifo
  #(parameter type payload_t = logic
  )
  (input  logic     clk_i
  , input  logic     reset_i

  , input  logic     v_i
  , input  payload_t data_i
  , output logic     ready_o

  , output logic     v_o
  , output payload_t data_o
  , input  logic     yumi_i
  );

  payload_t mem_r [2];
  logic rptr_r;
  logic wptr_r;
  logic full_r;
  logic empty_r;
  logic enq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];
  assign enq     = v_i & ~full_r;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r  <= 1'b0;
      wptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq) begin
        wptr_r <= ~wptr_r;
      end
      if (yumi_i) begin
        rptr_r <= ~rptr_r;
      end
      // flags only move when one side acts alone
      if (enq & ~yumi_i) begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end else if (yumi_i & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wh_dma_pkg.sv ====
/*
 * shared widths, flit type, DMA request packet and wormhole header flit
 */

`default_nettype none

package wh_dma_pkg;

  // flit width matches the cache DMA data width
  localparam int flit_width_p = 32;
  localparam int addr_width_p = 28;
  localparam int cid_width_p  = 1;
  localparam int len_width_p  = 4;

  typedef logic [flit_width_p-1:0] flit_t;

  typedef struct packed {
    logic                    write_not_read;
    logic [addr_width_p-1:0] addr;
  } dma_pkt_s;

  // len counts the flits after the header
  typedef struct packed {
    logic [flit_width_p-len_width_p-cid_width_p-2:0] unused;
    logic [len_width_p-1:0]                          len;
    logic [cid_width_p-1:0]                          cid;
    logic                                            write_not_read;
  } wh_header_s;

endpackage

`default_nettype wire

// ==== verilog/wh_link_if.sv ====
/*
 * bidirectional wormhole link, client and server modports
 */

`timescale 1ns/1ns
`default_nettype none

interface wh_link_if
  import wh_dma_pkg::*;
  ();

  // client to server
  logic  fwd_v;
  flit_t fwd_data;
  logic  fwd_ready;

  // server to client
  logic  rev_v;
  flit_t rev_data;
  logic  rev_ready;

  modport client (
    output fwd_v, fwd_data, rev_ready,
    input  fwd_ready, rev_v, rev_data
  );

  modport server (
    input  fwd_v, fwd_data, rev_ready,
    output fwd_ready, rev_v, rev_data
  );

endinterface

`default_nettype wire

// ==== verilog/wh_link_merge.sv ====
/*
 * two-to-one wormhole link merge
 * round-robin packet grant forward, cid steering on replies
 */

`timescale 1ns/1ns
`default_nettype none

module wh_link_merge
  import wh_dma_pkg::*;
  #(parameter int block_len_p = 4
  )
  (input  logic clk_i
  , input  logic reset_i

  , wh_link_if.server up0
  , wh_link_if.server up1
  , wh_link_if.client down
  );

  // longest packet body is addr plus one block
  localparam int max_len_lp   = block_len_p + 1;
  localparam int cnt_width_lp = $clog2(max_len_lp + 1);

  // forward path
  logic fwd_busy_r;
  logic fwd_sel_r;
  logic last_sel_r;
  logic [cnt_width_lp-1:0] fwd_cnt_r;
  logic pick;
  logic fwd_sel;
  logic fwd_fire;
  wh_header_s fwd_hdr;

  always_comb begin
    if (up0.fwd_v & up1.fwd_v) begin
      pick = ~last_sel_r;
    end else begin
      pick = up1.fwd_v;
    end
  end

  assign fwd_sel       = fwd_busy_r ? fwd_sel_r : pick;
  assign down.fwd_v    = fwd_sel ? up1.fwd_v : up0.fwd_v;
  assign down.fwd_data = fwd_sel ? up1.fwd_data : up0.fwd_data;
  assign up0.fwd_ready = down.fwd_ready & ~fwd_sel;
  assign up1.fwd_ready = down.fwd_ready & fwd_sel;
  assign fwd_fire      = down.fwd_v & down.fwd_ready;
  assign fwd_hdr       = down.fwd_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fwd_busy_r <= 1'b0;
      fwd_sel_r  <= 1'b0;
      last_sel_r <= 1'b1;
      fwd_cnt_r  <= '0;
    end else if (fwd_fire) begin
      if (!fwd_busy_r) begin
        // header flit locks the grant
        fwd_busy_r <= (fwd_hdr.len != '0);
        fwd_sel_r  <= fwd_sel;
        last_sel_r <= fwd_sel;
        fwd_cnt_r  <= cnt_width_lp'(fwd_hdr.len);
      end else begin
        fwd_cnt_r <= fwd_cnt_r - 1'b1;
        if (fwd_cnt_r == cnt_width_lp'(1)) begin
          fwd_busy_r <= 1'b0;
        end
      end
    end
  end

  // reverse path
  logic rev_busy_r;
  logic rev_sel_r;
  logic [cnt_width_lp-1:0] rev_cnt_r;
  logic rev_sel;
  logic rev_fire;
  wh_header_s rev_hdr;

  assign rev_hdr        = down.rev_data;
  assign rev_sel        = rev_busy_r ? rev_sel_r : rev_hdr.cid[0];
  assign up0.rev_v      = down.rev_v & ~rev_sel;
  assign up1.rev_v      = down.rev_v & rev_sel;
  assign up0.rev_data   = down.rev_data;
  assign up1.rev_data   = down.rev_data;
  assign down.rev_ready = rev_sel ? up1.rev_ready : up0.rev_ready;
  assign rev_fire       = down.rev_v & down.rev_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rev_busy_r <= 1'b0;
      rev_sel_r  <= 1'b0;
      rev_cnt_r  <= '0;
    end else if (rev_fire) begin
      if (!rev_busy_r) begin
        rev_busy_r <= (rev_hdr.len != '0);
        rev_sel_r  <= rev_sel;
        rev_cnt_r  <= cnt_width_lp'(rev_hdr.len);
      end else begin
        rev_cnt_r <= rev_cnt_r - 1'b1;
        if (rev_cnt_r == cnt_width_lp'(1)) begin
          rev_busy_r <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wh_mem_endpoint.sv ====
/*
 * block memory endpoint, stores write blocks and answers reads
 */

`timescale 1ns/1ns
`default_nettype none

module wh_mem_endpoint
  import wh_dma_pkg::*;
  #(parameter int block_len_p  = 4
  , parameter int mem_blocks_p = 16
  )
  (input  logic clk_i
  , input  logic reset_i

  , wh_link_if.server link
  );

  localparam int block_bytes_lp = block_len_p * (flit_width_p / 8);
  localparam int mem_words_lp   = mem_blocks_p * block_len_p;
  localparam int blk_width_lp   = (mem_blocks_p > 1) ? $clog2(mem_blocks_p) : 1;
  localparam int word_width_lp  = (mem_words_lp > 1) ? $clog2(mem_words_lp) : 1;
  localparam logic [len_width_p-1:0] last_lp = len_width_p'(block_len_p - 1);

  typedef enum logic [2:0] {
    EP_HEADER,
    EP_ADDR,
    EP_WDATA,
    EP_RHDR,
    EP_RDATA
  } ep_state_e;

  ep_state_e state_r;
  ep_state_e state_n;
  logic replying;

  flit_t in_data;
  logic  in_v;
  logic  in_ready;
  logic  in_yumi;

  // no new flits while a reply is on its way out
  assign replying       = (state_r == EP_RHDR) | (state_r == EP_RDATA);
  assign link.fwd_ready = in_ready & ~replying;

  two_fifo #(.payload_t(flit_t)) in_fifo (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.v_i    (link.fwd_v & ~replying)
    ,.data_i (link.fwd_data)
    ,.ready_o(in_ready)
    ,.v_o    (in_v)
    ,.data_o (in_data)
    ,.yumi_i (in_yumi)
  );

  flit_t mem_r [mem_words_lp];
  logic wnr_r;
  logic [cid_width_p-1:0] cid_r;
  logic [blk_width_lp-1:0] blk_r;
  logic [len_width_p-1:0] cnt_r;
  logic [word_width_lp-1:0] word_idx;
  logic [addr_width_p-1:0] in_addr;
  logic [blk_width_lp-1:0] in_blk;
  wh_header_s in_hdr;
  wh_header_s reply_hdr;

  assign in_hdr   = in_data;
  assign in_addr  = in_data[addr_width_p-1:0];
  // block index wraps at the memory depth
  assign in_blk   = blk_width_lp'((in_addr / block_bytes_lp) % mem_blocks_p);
  assign word_idx = word_width_lp'(blk_r * block_len_p + cnt_r);

  assign reply_hdr.unused         = '0;
  assign reply_hdr.len            = len_width_p'(block_len_p);
  assign reply_hdr.cid            = cid_r;
  assign reply_hdr.write_not_read = 1'b0;

  always_comb begin
    state_n       = state_r;
    in_yumi       = 1'b0;
    link.rev_v    = 1'b0;
    link.rev_data = mem_r[word_idx];

    case (state_r)
      EP_HEADER: begin
        in_yumi = in_v;
        if (in_v) begin
          state_n = EP_ADDR;
        end
      end
      EP_ADDR: begin
        in_yumi = in_v;
        if (in_v) begin
          state_n = wnr_r ? EP_WDATA : EP_RHDR;
        end
      end
      EP_WDATA: begin
        in_yumi = in_v;
        if (in_v & (cnt_r == last_lp)) begin
          state_n = EP_HEADER;
        end
      end
      EP_RHDR: begin
        link.rev_v    = 1'b1;
        link.rev_data = reply_hdr;
        if (link.rev_ready) begin
          state_n = EP_RDATA;
        end
      end
      EP_RDATA: begin
        link.rev_v = 1'b1;
        if (link.rev_ready & (cnt_r == last_lp)) begin
          state_n = EP_HEADER;
        end
      end
      default: begin
        state_n = EP_HEADER;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == EP_WDATA) & in_v) begin
      mem_r[word_idx] <= in_data;
    end
    if ((state_r == EP_HEADER) & in_v) begin
      wnr_r <= in_hdr.write_not_read;
      cid_r <= in_hdr.cid;
    end
    if ((state_r == EP_ADDR) & in_v) begin
      blk_r <= in_blk;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= EP_HEADER;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (state_n != state_r) begin
        cnt_r <= '0;
      end else if (((state_r == EP_WDATA) & in_v) | ((state_r == EP_RDATA) & link.rev_ready)) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
